// ==== run_tiny_rv.sh ====
#!/usr/bin/env bash
# Builds the tiny_rv testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_tiny_rv -f tiny_rv.f -o sim_tiny_rv \
  && ./obj_dir/sim_tiny_rv | tee /dev/stderr | grep -qxF "=== PASS ===" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb_tiny_rv.sv ====
// Testbench for the tiny_rv core with Wishbone slave models on both buses
// Runs a fixed program; concurrent assertions compare the buses with a reference model

`timescale 1ns/1ps

module tb_tiny_rv;

  localparam tiny_rv_pkg::word_t BOOT_ADDR = 32'h0000_0100;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  logic               clk = 1'b0;
  logic               rst_ni;
  logic               fetch_en_i;
  logic               halted_o;
  logic               ibus_cyc_o;
  logic               ibus_stb_o;
  tiny_rv_pkg::word_t ibus_adr_o;
  tiny_rv_pkg::word_t ibus_dat_i = '0;
  logic               ibus_ack_i = 1'b0;
  logic               dbus_cyc_o;
  logic               dbus_stb_o;
  logic               dbus_we_o;
  tiny_rv_pkg::word_t dbus_adr_o;
  tiny_rv_pkg::word_t dbus_dat_o;
  logic               dbus_ack_i = 1'b0;

  // Program and predicted stores
  tiny_rv_pkg::word_t prog [0:63];
  tiny_rv_pkg::word_t exp_adr [0:31];
  tiny_rv_pkg::word_t exp_dat [0:31];
  int prog_len = 0;
  int n_exp = 0;
  int n_sw = 0;
  int chain_st = 0;
  int zero_st = 0;
  // Progress and error bookkeeping
  int fetch_cnt = 0;
  int st_cnt = 0;
  int err_fetch = 0;
  int err_hold = 0;
  int err_halt = 0;
  int n_pass = 0;
  int n_fail = 0;
  int iwait;
  int dwait;
  bit store_bad [0:31];
  bit timed_out = 1'b0;
  logic [4:0]         st_idx;
  tiny_rv_pkg::word_t exp_fetch_adr;
  tiny_rv_pkg::word_t exp_adr_cur;
  tiny_rv_pkg::word_t exp_dat_cur;

  tiny_rv_top #(.BOOT_ADDR (BOOT_ADDR)) i_dut (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .fetch_en_i (fetch_en_i),
    .halted_o   (halted_o),
    .ibus_cyc_o (ibus_cyc_o),
    .ibus_stb_o (ibus_stb_o),
    .ibus_adr_o (ibus_adr_o),
    .ibus_dat_i (ibus_dat_i),
    .ibus_ack_i (ibus_ack_i),
    .dbus_cyc_o (dbus_cyc_o),
    .dbus_stb_o (dbus_stb_o),
    .dbus_we_o  (dbus_we_o),
    .dbus_adr_o (dbus_adr_o),
    .dbus_dat_o (dbus_dat_o),
    .dbus_ack_i (dbus_ack_i)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Program builder and reference model
  ////////////////////////////////////////////////////////////

  function automatic tiny_rv_pkg::word_t enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic tiny_rv_pkg::word_t enc_imm(input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic tiny_rv_pkg::word_t enc_reg(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  task automatic emit(input tiny_rv_pkg::word_t w);
    prog[prog_len[5:0]] = w;
    prog_len++;
  endtask

  // SW rs2, off(x10)
  task automatic emit_sw(input logic [4:0] rs2, input logic [11:0] off);
    emit({off[11:5], rs2, 5'd10, 3'b010, off[4:0], OP_STORE});
    n_sw++;
  endtask

  task automatic build_program();
    emit(enc_lui(10, 20'h00001));
    emit(enc_lui(1, 20'hABCDE));
    emit_sw(1, 0);
    emit(enc_imm(3'b000, 2, 1, 12'hFFB));
    emit_sw(2, 4);
    emit(enc_imm(3'b111, 3, 2, 12'h0F0));
    emit_sw(3, 8);
    emit(enc_imm(3'b110, 4, 3, 12'hF00));
    emit_sw(4, 12);
    emit(enc_imm(3'b100, 5, 4, 12'h555));
    emit_sw(5, 16);
    emit(enc_reg(7'h00, 3'b000, 6, 5, 2));
    emit_sw(6, 20);
    emit(enc_reg(7'h20, 3'b000, 7, 6, 1));
    emit_sw(7, 24);
    emit(enc_reg(7'h00, 3'b111, 8, 7, 5));
    emit_sw(8, 28);
    emit(enc_reg(7'h00, 3'b110, 9, 8, 3));
    emit_sw(9, 32);
    emit(enc_reg(7'h00, 3'b100, 11, 9, 6));
    emit_sw(11, 36);
    // Dependent chain on x12
    emit(enc_imm(3'b000, 12, 11, 12'h007));
    emit(enc_imm(3'b000, 12, 12, 12'h009));
    emit(enc_reg(7'h00, 3'b000, 12, 12, 12));
    emit(enc_reg(7'h00, 3'b100, 12, 12, 1));
    chain_st = n_sw;
    emit_sw(12, 40);
    // Write to x0 must be lost
    emit(enc_imm(3'b000, 0, 11, 12'h063));
    zero_st = n_sw;
    emit_sw(0, 44);
    // Unknown opcode halts the core
    emit(32'hFFFF_FFFF);
  endtask

  // In-order ISA model that stops at the first unknown word
  task automatic run_reference();
    tiny_rv_pkg::word_t regs [0:31];
    tiny_rv_pkg::word_t w;
    tiny_rv_pkg::word_t a;
    tiny_rv_pkg::word_t b;
    tiny_rv_pkg::word_t imm;
    tiny_rv_pkg::word_t res;
    bit                 known;
    int                 k;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    k = 0;
    known = 1'b1;
    while (k < prog_len && known) begin
      w   = prog[k[5:0]];
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      imm = {{20{w[31]}}, w[31:20]};
      res = '0;
      case (w[6:0])
        OP_LUI: res = {w[31:12], 12'h000};
        OP_IMM: begin
          case (w[14:12])
            3'b000:  res = a + imm;
            3'b100:  res = a ^ imm;
            3'b110:  res = a | imm;
            3'b111:  res = a & imm;
            default: known = 1'b0;
          endcase
        end
        OP_REG: begin
          case ({w[31:25], w[14:12]})
            {7'h00, 3'b000}: res = a + b;
            {7'h20, 3'b000}: res = a - b;
            {7'h00, 3'b100}: res = a ^ b;
            {7'h00, 3'b110}: res = a | b;
            {7'h00, 3'b111}: res = a & b;
            default:         known = 1'b0;
          endcase
        end
        OP_STORE: begin
          exp_adr[n_exp[4:0]] = a + {{20{w[31]}}, w[31:25], w[11:7]};
          exp_dat[n_exp[4:0]] = b;
          n_exp++;
        end
        default: known = 1'b0;
      endcase
      if (known && (w[6:0] != OP_STORE) && (w[11:7] != 5'd0)) begin
        regs[w[11:7]] = res;
      end
      k++;
    end
  endtask

  // Words past the program decode as illegal with a pattern that follows the address
  function automatic tiny_rv_pkg::word_t imem_read(input tiny_rv_pkg::word_t adr);
    tiny_rv_pkg::word_t idx;
    idx = (adr - BOOT_ADDR) >> 2;
    if (adr >= BOOT_ADDR && idx < prog_len) begin
      return prog[idx[5:0]];
    end
    return {adr[31:7] ^ {18'h0, adr[6:0]}, 7'h7f};
  endfunction

  ////////////////////////////////////////////////////////////
  // Wishbone slave models with 0 to 3 wait cycles
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    #2;
    if (!rst_ni || ibus_ack_i) begin
      ibus_ack_i = 1'b0;
      iwait      = -1;
    end else if (ibus_cyc_o && ibus_stb_o) begin
      if (iwait < 0) begin
        iwait = int'($urandom_range(3));
      end
      if (iwait == 0) begin
        ibus_dat_i = imem_read(ibus_adr_o);
        ibus_ack_i = 1'b1;
      end else begin
        iwait--;
      end
    end
  end

  always @(posedge clk) begin
    #2;
    if (!rst_ni || dbus_ack_i) begin
      dbus_ack_i = 1'b0;
      dwait      = -1;
    end else if (dbus_cyc_o && dbus_stb_o) begin
      if (dwait < 0) begin
        dwait = int'($urandom_range(3));
      end
      if (dwait == 0) begin
        dbus_ack_i = 1'b1;
      end else begin
        dwait--;
      end
    end
  end

  // Completed transfers on each bus
  always @(posedge clk) begin
    if (rst_ni && ibus_cyc_o && ibus_ack_i) begin
      fetch_cnt <= fetch_cnt + 1;
    end
    if (rst_ni && dbus_cyc_o && dbus_ack_i) begin
      st_cnt <= st_cnt + 1;
    end
  end

  assign st_idx        = st_cnt[4:0];
  assign exp_fetch_adr = BOOT_ADDR + (fetch_cnt << 2);
  assign exp_adr_cur   = exp_adr[st_idx];
  assign exp_dat_cur   = exp_dat[st_idx];

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_fetch_order: assert property (@(posedge clk) disable iff (!rst_ni)
    (ibus_cyc_o && ibus_ack_i) |-> (ibus_adr_o == exp_fetch_adr))
  else begin
    err_fetch++;
    $display("ERR %0t: fetch address %h, expected %h", $time,
             $sampled(ibus_adr_o), $sampled(exp_fetch_adr));
  end

  a_store_value: assert property (@(posedge clk) disable iff (!rst_ni)
    (dbus_cyc_o && dbus_ack_i && (st_cnt < n_exp)) |->
    (dbus_we_o && (dbus_adr_o == exp_adr_cur) && (dbus_dat_o == exp_dat_cur)))
  else begin
    store_bad[$sampled(st_idx)] = 1'b1;
    $display("ERR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
             $sampled(st_cnt), $sampled(dbus_dat_o), $sampled(dbus_adr_o),
             $sampled(exp_dat_cur), $sampled(exp_adr_cur));
  end

  a_ibus_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    (ibus_cyc_o && !ibus_ack_i) |=> (ibus_cyc_o && ibus_stb_o && $stable(ibus_adr_o)))
  else begin
    err_hold++;
    $display("ERR %0t: ibus request dropped or changed before ack", $time);
  end

  a_dbus_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    (dbus_cyc_o && !dbus_ack_i) |=> (dbus_cyc_o && dbus_stb_o && dbus_we_o &&
                                     $stable(dbus_adr_o) && $stable(dbus_dat_o)))
  else begin
    err_hold++;
    $display("ERR %0t: dbus request dropped or changed before ack", $time);
  end

  // Strobe only inside a cycle and dbus always a write
  a_bus_shape: assert property (@(posedge clk) disable iff (!rst_ni)
    (!ibus_stb_o || ibus_cyc_o) && (!dbus_stb_o || (dbus_cyc_o && dbus_we_o)))
  else begin
    err_hold++;
    $display("ERR %0t: strobe without cycle or write enable", $time);
  end

  a_no_extra_store: assert property (@(posedge clk) disable iff (!rst_ni)
    (dbus_cyc_o && dbus_ack_i) |-> (st_cnt < n_exp))
  else begin
    err_halt++;
    $display("Store beyond the program reached the data bus at %0t", $time);
  end

  a_no_fetch_after_halt: assert property (@(posedge clk) disable iff (!rst_ni)
    (halted_o && !ibus_cyc_o) |=> !ibus_cyc_o)
  else begin
    err_halt++;
    $display("New ibus request started after the halt at %0t", $time);
  end

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  function automatic bit stores_clean(input int first, input int last);
    bit ok;
    ok = 1'b1;
    for (int i = first; i <= last; i++) begin
      if (store_bad[i[4:0]]) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: failed", name);
    end
  endtask

  initial begin : main
    int cycles;
    bit halt_seen;
    bit ibus_idle;
    rst_ni     = 1'b0;
    fetch_en_i = 1'b0;
    void'($urandom(70550));
    build_program();
    run_reference();
    repeat (3) @(posedge clk);
    #2 rst_ni = 1'b1;
    @(posedge clk);
    #2 fetch_en_i = 1'b1;

    cycles = 0;
    while (st_cnt < n_exp && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (st_cnt < n_exp) begin
      timed_out = 1'b1;
      $display("Timed out with only %0d of %0d stores seen", st_cnt, n_exp);
    end
    report_test("fetch order", !timed_out && err_fetch == 0 && fetch_cnt >= n_exp);
    report_test("alu results", !timed_out && stores_clean(0, chain_st - 1));
    report_test("dependent chain", !timed_out && stores_clean(chain_st, chain_st));
    report_test("x0 write", !timed_out && stores_clean(zero_st, zero_st));
    report_test("random handshake", !timed_out && err_hold == 0);

    // Halt and then completion of the open request
    cycles = 0;
    while (!halted_o && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    halt_seen = halted_o;
    cycles = 0;
    while (ibus_cyc_o && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    ibus_idle = !ibus_cyc_o;
    if (!halt_seen || !ibus_idle) begin
      timed_out = 1'b1;
      $display("Timed out waiting for the halt and an idle instruction bus");
    end
    repeat (20) @(posedge clk);
    report_test("illegal halt", halt_seen && ibus_idle && err_halt == 0 && st_cnt == n_exp);

    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tiny_rv.f ====
tiny_rv_pkg.sv
tiny_rv_pipe_buf.sv
tiny_rv_fetch.sv
tiny_rv_regfile.sv
tiny_rv_decode.sv
tiny_rv_execute.sv
tiny_rv_top.sv
tb_tiny_rv.sv

// ==== tiny_rv_decode.sv ====
// Decode stage: field split, operand read, hazard stall, illegal halt
// Holds the register file; its write port arrives from execute

`timescale 1ns/1ps

module tiny_rv_decode (
  input  logic                    clk,
  input  logic                    rst_ni,
  // From fetch buffer
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  tiny_rv_pkg::fetch_pkt_t in_pkt_i,
  // To exec buffer
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output tiny_rv_pkg::exec_pkt_t  out_pkt_o,
  // Pending destination further down the pipe
  input  logic                    busy_rd_valid_i,
  input  tiny_rv_pkg::reg_addr_t  busy_rd_i,
  // Register write-back from execute
  input  logic                    we_i,
  input  tiny_rv_pkg::reg_addr_t  waddr_i,
  input  tiny_rv_pkg::word_t      wdata_i,
  output logic                    halted_o
);

  tiny_rv_pkg::word_t     instr;
  tiny_rv_pkg::reg_addr_t rs1;
  tiny_rv_pkg::reg_addr_t rs2;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  tiny_rv_pkg::word_t     imm_i;
  tiny_rv_pkg::word_t     imm_s;
  tiny_rv_pkg::word_t     imm_u;
  tiny_rv_pkg::word_t     rs1_val;
  tiny_rv_pkg::word_t     rs2_val;
  tiny_rv_pkg::exec_pkt_t pkt;
  logic                   illegal;
  logic                   uses_rs1;
  logic                   uses_rs2;
  logic                   hazard;
  logic                   halted_q;

  // Instruction fields
  assign instr  = in_pkt_i.instr;
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};

  tiny_rv_regfile u_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rs1_val),
    .rdata_b_o (rs2_val),
    .we_i      (we_i),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i)
  );

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    pkt            = '0;
    pkt.alu_op     = tiny_rv_pkg::ALU_ADD;
    pkt.op_a       = rs1_val;
    pkt.op_b       = rs2_val;
    pkt.store_data = rs2_val;
    pkt.rd         = instr[11:7];
    illegal        = 1'b0;
    uses_rs1       = 1'b1;
    uses_rs2       = 1'b0;
    case (tiny_rv_pkg::opcode_t'(instr[6:0]))
      tiny_rv_pkg::OPC_LUI: begin
        pkt.alu_op = tiny_rv_pkg::ALU_PASS_B;
        pkt.op_b   = imm_u;
        pkt.rd_we  = 1'b1;
        uses_rs1   = 1'b0;
      end
      tiny_rv_pkg::OPC_OP_IMM: begin
        pkt.op_b  = imm_i;
        pkt.rd_we = 1'b1;
        case (funct3)
          3'b000:  pkt.alu_op = tiny_rv_pkg::ALU_ADD;
          3'b100:  pkt.alu_op = tiny_rv_pkg::ALU_XOR;
          3'b110:  pkt.alu_op = tiny_rv_pkg::ALU_OR;
          3'b111:  pkt.alu_op = tiny_rv_pkg::ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      tiny_rv_pkg::OPC_OP: begin
        pkt.rd_we = 1'b1;
        uses_rs2  = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: pkt.alu_op = tiny_rv_pkg::ALU_ADD;
          {7'h20, 3'b000}: pkt.alu_op = tiny_rv_pkg::ALU_SUB;
          {7'h00, 3'b100}: pkt.alu_op = tiny_rv_pkg::ALU_XOR;
          {7'h00, 3'b110}: pkt.alu_op = tiny_rv_pkg::ALU_OR;
          {7'h00, 3'b111}: pkt.alu_op = tiny_rv_pkg::ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      tiny_rv_pkg::OPC_STORE: begin
        // Address is rs1 plus offset, data is rs2
        pkt.op_b  = imm_s;
        pkt.store = 1'b1;
        uses_rs2  = 1'b1;
        // Word stores only
        illegal   = (funct3 != 3'b010);
      end
      default: illegal = 1'b1;
    endcase
  end

  // RAW on a pending destination, x0 never conflicts
  assign hazard = busy_rd_valid_i && (busy_rd_i != '0) &&
                  ((uses_rs1 && (rs1 == busy_rd_i)) || (uses_rs2 && (rs2 == busy_rd_i)));

  // Illegal words and anything after the halt are consumed and dropped
  assign out_valid_o = in_valid_i && !halted_q && !illegal && !hazard;
  assign in_ready_o  = halted_q || illegal || (!hazard && out_ready_i);
  assign out_pkt_o   = pkt;

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q <= 1'b0;
    end else if (in_valid_i && illegal) begin
      halted_q <= 1'b1;
    end
  end

  assign halted_o = halted_q;

endmodule

// ==== tiny_rv_execute.sv ====
// Execute stage: ALU, register write-back and Wishbone classic store master
// ALU ops retire in the cycle they are taken; a store holds until ack

`timescale 1ns/1ps

module tiny_rv_execute (
  input  logic                   clk,
  input  logic                   rst_ni,
  // From exec buffer
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  tiny_rv_pkg::exec_pkt_t in_pkt_i,
  // Register file write port
  output logic                   rf_we_o,
  output tiny_rv_pkg::reg_addr_t rf_waddr_o,
  output tiny_rv_pkg::word_t     rf_wdata_o,
  // Destination held in this stage
  output logic                   busy_rd_valid_o,
  output tiny_rv_pkg::reg_addr_t busy_rd_o,
  // Data bus
  output logic                   dbus_cyc_o,
  output logic                   dbus_stb_o,
  output logic                   dbus_we_o,
  output tiny_rv_pkg::word_t     dbus_adr_o,
  output tiny_rv_pkg::word_t     dbus_dat_o,
  input  logic                   dbus_ack_i
);

  typedef enum logic {
    S_IDLE,
    S_BUS
  } state_e;

  state_e             state_q;
  tiny_rv_pkg::word_t result;
  tiny_rv_pkg::word_t adr_q;
  tiny_rv_pkg::word_t dat_q;
  logic               store_start;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (in_pkt_i.alu_op)
      tiny_rv_pkg::ALU_ADD:    result = in_pkt_i.op_a + in_pkt_i.op_b;
      tiny_rv_pkg::ALU_SUB:    result = in_pkt_i.op_a - in_pkt_i.op_b;
      tiny_rv_pkg::ALU_AND:    result = in_pkt_i.op_a & in_pkt_i.op_b;
      tiny_rv_pkg::ALU_OR:     result = in_pkt_i.op_a | in_pkt_i.op_b;
      tiny_rv_pkg::ALU_XOR:    result = in_pkt_i.op_a ^ in_pkt_i.op_b;
      tiny_rv_pkg::ALU_PASS_B: result = in_pkt_i.op_b;
      default:                 result = '0;
    endcase
  end

  // Stores leave only on the ack cycle
  assign in_ready_o = !in_pkt_i.store || ((state_q == S_BUS) && dbus_ack_i);

  // Write-back in the cycle the item is taken
  assign rf_we_o    = in_valid_i && in_ready_o && in_pkt_i.rd_we;
  assign rf_waddr_o = in_pkt_i.rd;
  assign rf_wdata_o = result;

  assign busy_rd_valid_o = in_valid_i && in_pkt_i.rd_we;
  assign busy_rd_o       = in_pkt_i.rd;

  ////////////////////////////////////////////////////////////
  // Store FSM
  ////////////////////////////////////////////////////////////

  assign store_start = (state_q == S_IDLE) && in_valid_i && in_pkt_i.store;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (store_start) begin
            state_q <= S_BUS;
          end
        end
        S_BUS: begin
          if (dbus_ack_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Address from the adder and data from rs2
  always_ff @(posedge clk) begin
    if (store_start) begin
      adr_q <= result;
      dat_q <= in_pkt_i.store_data;
    end
  end

  assign dbus_cyc_o = (state_q == S_BUS);
  assign dbus_stb_o = (state_q == S_BUS);
  assign dbus_we_o  = (state_q == S_BUS);
  assign dbus_adr_o = adr_q;
  assign dbus_dat_o = dat_q;

  // Strobe inside a cycle, with the store item held at the input until ack
  a_dbus_hold: assert property (
    @(posedge clk) disable iff (!rst_ni)
    dbus_stb_o |-> (dbus_cyc_o && in_valid_i && in_pkt_i.store)
  );

endmodule

// ==== tiny_rv_fetch.sv ====
// Instruction fetch stage: sequential PC and Wishbone classic read master
// One request in flight; the fetched word is offered to the fetch buffer

`timescale 1ns/1ps

module tiny_rv_fetch #(
  parameter tiny_rv_pkg::word_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   fetch_en_i,
  // From decode, blocks new requests
  input  logic                   halt_i,
  // Instruction bus
  output logic                   ibus_cyc_o,
  output logic                   ibus_stb_o,
  output tiny_rv_pkg::word_t     ibus_adr_o,
  input  tiny_rv_pkg::word_t     ibus_dat_i,
  input  logic                   ibus_ack_i,
  // To fetch buffer
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output tiny_rv_pkg::fetch_pkt_t out_pkt_o
);

  typedef enum logic {
    S_IDLE,
    S_BUS
  } state_e;

  state_e                  state_q;
  tiny_rv_pkg::word_t      pc_q;
  logic                    out_valid_q;
  tiny_rv_pkg::fetch_pkt_t pkt_q;
  logic                    start_req;

  // New request only when the output slot is free or draining
  assign start_req = (state_q == S_IDLE) && fetch_en_i && !halt_i &&
                     (!out_valid_q || out_ready_i);

  ////////////////////////////////////////////////////////////
  // Bus FSM and PC
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      pc_q    <= BOOT_ADDR;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_req) begin
            state_q <= S_BUS;
          end
        end
        S_BUS: begin
          // Open request always completes, even after halt
          if (ibus_ack_i) begin
            state_q <= S_IDLE;
            pc_q    <= pc_q + 32'd4;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Output slot valid
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if ((state_q == S_BUS) && ibus_ack_i) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Captured word and its PC
  always_ff @(posedge clk) begin
    if ((state_q == S_BUS) && ibus_ack_i) begin
      pkt_q.instr <= ibus_dat_i;
      pkt_q.pc    <= pc_q;
    end
  end

  assign ibus_cyc_o  = (state_q == S_BUS);
  assign ibus_stb_o  = (state_q == S_BUS);
  assign ibus_adr_o  = pc_q;
  assign out_valid_o = out_valid_q;
  assign out_pkt_o   = pkt_q;

  // Request held with the same address until ack
  a_ibus_hold: assert property (
    @(posedge clk) disable iff (!rst_ni)
    (ibus_cyc_o && !ibus_ack_i) |=> (ibus_cyc_o && ibus_stb_o && $stable(ibus_adr_o))
  );

endmodule

// ==== tiny_rv_pipe_buf.sv ====
// One-entry valid/ready register stage between two pipeline stages
// The payload type is set per instance

`timescale 1ns/1ps

module tiny_rv_pipe_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_ni,
  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  // Stalled item must not change under the consumer
  a_stable_when_stalled: assert property (
    @(posedge clk) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o))
  );

endmodule

// ==== tiny_rv_pkg.sv ====
// Shared widths, encodings and stage payloads of the tiny_rv core
// Every RTL module refers to these by scoped name

package tiny_rv_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////////////////////////

  // Data and address width
  parameter int unsigned XLEN       = 32;
  // Register index width
  parameter int unsigned REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_STORE  = 7'b0100011
  } opcode_t;

  // ALU operations, PASS_B serves LUI
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_t;

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////

  // Fetch to decode
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_pkt_t;

  // Decode to execute
  typedef struct packed {
    alu_op_t   alu_op;
    word_t     op_a;
    word_t     op_b;
    // rs2 value, only meaningful for stores
    word_t     store_data;
    reg_addr_t rd;
    logic      rd_we;
    logic      store;
  } exec_pkt_t;

endpackage

// ==== tiny_rv_regfile.sv ====
// Integer register file, two combinational reads and one write
// x0 reads zero; a read of the register being written sees the new value

`timescale 1ns/1ps

module tiny_rv_regfile (
  input  logic                   clk,
  input  logic                   rst_ni,
  // Read ports
  input  tiny_rv_pkg::reg_addr_t raddr_a_i,
  input  tiny_rv_pkg::reg_addr_t raddr_b_i,
  output tiny_rv_pkg::word_t     rdata_a_o,
  output tiny_rv_pkg::word_t     rdata_b_o,
  // Write port
  input  logic                   we_i,
  input  tiny_rv_pkg::reg_addr_t waddr_i,
  input  tiny_rv_pkg::word_t     wdata_i
);

  // No storage for x0
  tiny_rv_pkg::word_t regs_q [31:1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read with write-through
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if (raddr_a_i != '0) begin
      rdata_a_o = (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs_q[raddr_a_i];
    end
    if (raddr_b_i != '0) begin
      rdata_b_o = (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs_q[raddr_b_i];
    end
  end

endmodule

// ==== tiny_rv_top.sv ====
// Top level of the tiny_rv core
// Fetch, two pipeline buffers, decode and execute on plain Wishbone ports

`timescale 1ns/1ps

module tiny_rv_top #(
  parameter tiny_rv_pkg::word_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rst_ni,
  input  logic               fetch_en_i,
  output logic               halted_o,
  // Instruction bus
  output logic               ibus_cyc_o,
  output logic               ibus_stb_o,
  output tiny_rv_pkg::word_t ibus_adr_o,
  input  tiny_rv_pkg::word_t ibus_dat_i,
  input  logic               ibus_ack_i,
  // Data bus
  output logic               dbus_cyc_o,
  output logic               dbus_stb_o,
  output logic               dbus_we_o,
  output tiny_rv_pkg::word_t dbus_adr_o,
  output tiny_rv_pkg::word_t dbus_dat_o,
  input  logic               dbus_ack_i
);

  // Fetch to fetch buffer
  logic                    if_valid;
  logic                    if_ready;
  tiny_rv_pkg::fetch_pkt_t if_pkt;
  // Fetch buffer to decode
  logic                    id_valid;
  logic                    id_ready;
  tiny_rv_pkg::fetch_pkt_t id_pkt;
  // Decode to exec buffer
  logic                    dx_valid;
  logic                    dx_ready;
  tiny_rv_pkg::exec_pkt_t  dx_pkt;
  // Exec buffer to execute
  logic                    ex_valid;
  logic                    ex_ready;
  tiny_rv_pkg::exec_pkt_t  ex_pkt;
  // Write-back and pending destination
  logic                    rf_we;
  tiny_rv_pkg::reg_addr_t  rf_waddr;
  tiny_rv_pkg::word_t      rf_wdata;
  logic                    busy_rd_valid;
  tiny_rv_pkg::reg_addr_t  busy_rd;

  tiny_rv_fetch #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_fetch (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .fetch_en_i  (fetch_en_i),
    .halt_i      (halted_o),
    .ibus_cyc_o  (ibus_cyc_o),
    .ibus_stb_o  (ibus_stb_o),
    .ibus_adr_o  (ibus_adr_o),
    .ibus_dat_i  (ibus_dat_i),
    .ibus_ack_i  (ibus_ack_i),
    .out_valid_o (if_valid),
    .out_ready_i (if_ready),
    .out_pkt_o   (if_pkt)
  );

  tiny_rv_pipe_buf #(
    .payload_t (tiny_rv_pkg::fetch_pkt_t)
  ) u_fetch_buf (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .in_valid_i  (if_valid),
    .in_ready_o  (if_ready),
    .in_data_i   (if_pkt),
    .out_valid_o (id_valid),
    .out_ready_i (id_ready),
    .out_data_o  (id_pkt)
  );

  tiny_rv_decode u_decode (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .in_valid_i      (id_valid),
    .in_ready_o      (id_ready),
    .in_pkt_i        (id_pkt),
    .out_valid_o     (dx_valid),
    .out_ready_i     (dx_ready),
    .out_pkt_o       (dx_pkt),
    .busy_rd_valid_i (busy_rd_valid),
    .busy_rd_i       (busy_rd),
    .we_i            (rf_we),
    .waddr_i         (rf_waddr),
    .wdata_i         (rf_wdata),
    .halted_o        (halted_o)
  );

  tiny_rv_pipe_buf #(
    .payload_t (tiny_rv_pkg::exec_pkt_t)
  ) u_exec_buf (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .in_valid_i  (dx_valid),
    .in_ready_o  (dx_ready),
    .in_data_i   (dx_pkt),
    .out_valid_o (ex_valid),
    .out_ready_i (ex_ready),
    .out_data_o  (ex_pkt)
  );

  // Execute works on the exec buffer entry and reports its pending destination
  tiny_rv_execute u_execute (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .in_valid_i      (ex_valid),
    .in_ready_o      (ex_ready),
    .in_pkt_i        (ex_pkt),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .busy_rd_valid_o (busy_rd_valid),
    .busy_rd_o       (busy_rd),
    .dbus_cyc_o      (dbus_cyc_o),
    .dbus_stb_o      (dbus_stb_o),
    .dbus_we_o       (dbus_we_o),
    .dbus_adr_o      (dbus_adr_o),
    .dbus_dat_o      (dbus_dat_o),
    .dbus_ack_i      (dbus_ack_i)
  );

endmodule
